// ==== common/icache_pkg.sv ====
/*
  instruction cache shared definitions
  fixed geometry, fill command encoding and controller states
*/

package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // word and address widths
  //////////////////////////////////////////////////////////////////////

  // data word, also the parcel size
  localparam int XLEN = 32;

  // physical address
  localparam int PLEN = 32;

  //////////////////////////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////////////////////////

  localparam int WAYS       = 2;
  localparam int SETS       = 16;
  localparam int LINE_WORDS = 4;

  // address split, low to high
  localparam int BYTE_OFFS_BITS = $clog2(XLEN / 8);
  localparam int WORD_OFFS_BITS = $clog2(LINE_WORDS);
  localparam int IDX_BITS       = $clog2(SETS);
  localparam int TAG_BITS       = PLEN - IDX_BITS - WORD_OFFS_BITS - BYTE_OFFS_BITS;

  // one full line as a flat vector, word 0 in the low bits
  localparam int LINE_BITS = LINE_WORDS * XLEN;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // command pulse from controller to fill unit
  typedef enum logic [1:0] {
    FILL_NOP,
    FILL_LINE,
    FILL_WORD
  } fill_cmd_t;

  // cache controller states
  typedef enum logic [2:0] {
    ARMED,
    INVALIDATE,
    NONCACHEABLE,
    READ,
    RECOVER0,
    RECOVER1
  } ctrl_state_t;

endpackage

// ==== common/icache_fill_if.sv ====
/*
  fill bus between cache controller, fill unit and cache arrays
  command, returned beats, line buffer, completion and fill way
*/

`timescale 1ns/100ps

interface icache_fill_if
  import icache_pkg::*;
();

  // command pulse and address, from controller
  fill_cmd_t                   cmd;
  logic [PLEN-1:0]             adr;

  // per word beat, from fill unit
  logic                        beat_ack;
  logic [XLEN-1:0]             beat_word;
  logic [WORD_OFFS_BITS-1:0]   beat_idx;

  // completion, err ends the transfer early
  logic                        err;
  logic                        done;
  logic [LINE_BITS-1:0]        line;

  // one-hot victim way, latched by the arrays
  logic [WAYS-1:0]             way;

  modport ctrl   (output cmd, adr,
                  input  beat_ack, beat_word, beat_idx, err, done);

  modport filler (input  cmd, adr,
                  output beat_ack, beat_word, beat_idx, err, done, line);

  modport memory (input  cmd, adr, err, done, line,
                  output way);

endinterface

// ==== icache/icache_fsm.sv ====
/*
  instruction cache control FSM
  serves hits in ARMED, starts line and single word fills,
  selects the parcel and drives stall and parcel flags
*/

`timescale 1ns/100ps

module icache_fsm
  import icache_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // fetch side
  input  logic                 req_i,
  input  logic [PLEN-1:0]      adr_i,
  input  logic                 cacheable_i,
  input  logic                 flush_i,
  input  logic                 invalidate_i,
  output logic                 stall_o,
  output logic [XLEN-1:0]      parcel_o,
  output logic                 parcel_valid_o,
  output logic                 parcel_error_o,
  output logic                 parcel_misaligned_o,

  // cache arrays
  input  logic                 hit_i,
  input  logic [XLEN-1:0]      hit_word_i,
  output logic                 invalidate_all_o,

  // fill unit
  icache_fill_if.ctrl          fill
);

  ctrl_state_t                 state;
  logic                        invalidate_hold;
  logic                        inv_pending;
  logic                        misaligned;
  logic                        valid_req;
  logic                        cache_ack;
  logic                        start_fill;
  logic                        waiting;
  logic                        deliver;
  logic [WORD_OFFS_BITS-1:0]   req_idx;

  //////////////////////////////////////////////////////////////////////
  // request qualification
  //////////////////////////////////////////////////////////////////////

  // parcels are full words
  assign misaligned  = |adr_i[BYTE_OFFS_BITS-1:0];
  assign valid_req   = req_i & ~misaligned & ~flush_i;
  assign inv_pending = invalidate_i | invalidate_hold;

  // hit served straight from the arrays
  assign cache_ack = valid_req & cacheable_i & hit_i;

  // miss or noncacheable, only when no invalidate is waiting
  assign start_fill = (state == ARMED) & ~inv_pending & valid_req &
                      (~cacheable_i | ~hit_i);

  // keep invalidate until INVALIDATE has run
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      invalidate_hold <= 1'b0;
    else
      invalidate_hold <= invalidate_i | (invalidate_hold & ~invalidate_all_o);

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      state            <= ARMED;
      invalidate_all_o <= 1'b0;
      fill.cmd         <= FILL_NOP;
    end
    else
    begin
      // command is a single cycle pulse
      fill.cmd <= FILL_NOP;

      unique case (state)
        ARMED:
          if (inv_pending)
          begin
            state            <= INVALIDATE;
            invalidate_all_o <= 1'b1;
          end
          else if (start_fill && !cacheable_i)
          begin
            state    <= NONCACHEABLE;
            fill.cmd <= FILL_WORD;
          end
          else if (start_fill)
          begin
            state    <= READ;
            fill.cmd <= FILL_LINE;
          end

        // valid bits cleared in this cycle
        INVALIDATE:
        begin
          state            <= RECOVER0;
          invalidate_all_o <= 1'b0;
        end

        // single read, done follows the beat or the error
        NONCACHEABLE:
          if (fill.done)
            state <= ARMED;

        // line written by the arrays on done
        READ:
          if (fill.done)
            state <= RECOVER0;

        // arrays settle after the write
        RECOVER0:
          state <= RECOVER1;

        RECOVER1:
          state <= ARMED;

        default:
          state <= ARMED;
      endcase
    end

  // fill address and requested word, taken with the command
  always_ff @(posedge clk_i)
    if (start_fill)
    begin
      fill.adr <= adr_i;
      req_idx  <= adr_i[BYTE_OFFS_BITS +: WORD_OFFS_BITS];
    end

  // fetch still owed a word or an error
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      waiting <= 1'b0;
    else if (start_fill)
      waiting <= 1'b1;
    else if (flush_i || deliver || parcel_error_o)
      waiting <= 1'b0;

  //////////////////////////////////////////////////////////////////////
  // parcel out
  //////////////////////////////////////////////////////////////////////

  // beat carrying the owed word
  always_comb
    unique case (state)
      NONCACHEABLE: deliver = waiting & valid_req & fill.beat_ack;
      READ:         deliver = waiting & valid_req & fill.beat_ack &
                              (fill.beat_idx == req_idx);
      default:      deliver = 1'b0;
    endcase

  // beat data while filling, array word otherwise
  assign parcel_o = (state == READ || state == NONCACHEABLE) ? fill.beat_word : hit_word_i;

  assign parcel_valid_o      = (state == ARMED) ? cache_ack : deliver;
  assign parcel_error_o      = waiting & valid_req & fill.err;
  assign parcel_misaligned_o = req_i & misaligned;

  // stall until the request is answered
  always_comb
    unique case (state)
      ARMED:        stall_o = valid_req & ~cache_ack;
      NONCACHEABLE: stall_o = ~(deliver | parcel_error_o);
      READ:         stall_o = ~(deliver | parcel_error_o);
      default:      stall_o = 1'b1;
    endcase

endmodule

// ==== icache/icache_memory.sv ====
/*
  instruction cache arrays
  tag, valid and data per way, hit lookup, round-robin victim,
  line write on fill completion and invalidate of all lines
*/

`timescale 1ns/100ps

module icache_memory
  import icache_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // lookup
  input  logic [PLEN-1:0]      adr_i,
  input  logic                 invalidate_all_i,
  output logic                 hit_o,
  output logic [XLEN-1:0]      hit_word_o,

  // fill side
  icache_fill_if.memory        fill
);

  // storage
  logic [TAG_BITS-1:0]         tag_q  [WAYS][SETS];
  logic [LINE_BITS-1:0]        data_q [WAYS][SETS];
  logic [WAYS-1:0][SETS-1:0]   valid_q;
  logic [SETS-1:0]             rr_q;

  // lookup address fields
  logic [TAG_BITS-1:0]         core_tag;
  logic [IDX_BITS-1:0]         idx;
  logic [WORD_OFFS_BITS-1:0]   word_offs;
  logic [WAYS-1:0]             hit_way;
  logic [LINE_BITS-1:0]        hit_line;

  // fill side
  logic [IDX_BITS-1:0]         fill_idx;
  logic [IDX_BITS-1:0]         wr_idx;
  logic [TAG_BITS-1:0]         wr_tag;
  logic                        line_pending;
  logic                        line_write;

  //////////////////////////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////////////////////////

  assign core_tag  = adr_i[PLEN-1 -: TAG_BITS];
  assign idx       = adr_i[BYTE_OFFS_BITS + WORD_OFFS_BITS +: IDX_BITS];
  assign word_offs = adr_i[BYTE_OFFS_BITS +: WORD_OFFS_BITS];

  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++)
      hit_way[w] = valid_q[w][idx] & (tag_q[w][idx] == core_tag);
  end

  // at most one way hits
  always_comb
  begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++)
      if (hit_way[w])
        hit_line = data_q[w][idx];
  end

  assign hit_o      = |hit_way;
  assign hit_word_o = hit_line[word_offs * XLEN +: XLEN];

  //////////////////////////////////////////////////////////////////////
  // fill
  //////////////////////////////////////////////////////////////////////

  assign fill_idx = fill.adr[BYTE_OFFS_BITS + WORD_OFFS_BITS +: IDX_BITS];

  // victim and write location, taken with the line command
  always_ff @(posedge clk_i)
    if (fill.cmd == FILL_LINE)
    begin
      fill.way <= WAYS'(1) << rr_q[fill_idx];
      wr_idx   <= fill_idx;
      wr_tag   <= fill.adr[PLEN-1 -: TAG_BITS];
    end

  // a failed burst leaves the arrays alone
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      line_pending <= 1'b0;
    else if (fill.cmd == FILL_LINE)
      line_pending <= 1'b1;
    else if (fill.err || fill.done)
      line_pending <= 1'b0;

  assign line_write = fill.done & line_pending;

  always_ff @(posedge clk_i)
    if (line_write)
      for (int w = 0; w < WAYS; w++)
        if (fill.way[w])
        begin
          data_q[w][wr_idx] <= fill.line;
          tag_q[w][wr_idx]  <= wr_tag;
        end

  // valid bits and round-robin pointers
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      valid_q <= '0;
      rr_q    <= '0;
    end
    else if (invalidate_all_i)
      valid_q <= '0;
    else if (line_write)
    begin
      for (int w = 0; w < WAYS; w++)
        if (fill.way[w])
          valid_q[w][wr_idx] <= 1'b1;
      // next fill of this set goes to the other way
      rr_q[wr_idx] <= ~rr_q[wr_idx];
    end

endmodule

// ==== icache/icache_fill.sv ====
/*
  instruction cache fill unit
  runs four word reads for a line or one read for a noncacheable
  fetch, reports each beat and gathers the line buffer
*/

`timescale 1ns/100ps

module icache_fill
  import icache_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // memory port
  output logic                 mem_req_o,
  output logic [PLEN-1:0]      mem_adr_o,
  input  logic                 mem_ack_i,
  input  logic [XLEN-1:0]      mem_q_i,
  input  logic                 mem_err_i,

  // controller and arrays
  icache_fill_if.filler        fill
);

  localparam int BASE_BITS = PLEN - WORD_OFFS_BITS - BYTE_OFFS_BITS;

  logic [BASE_BITS-1:0]        base_q;
  logic [WORD_OFFS_BITS-1:0]   cnt_q;
  logic                        line_mode_q;
  logic [LINE_BITS-1:0]        line_q;
  logic                        last_beat;

  //////////////////////////////////////////////////////////////////////
  // beats
  //////////////////////////////////////////////////////////////////////

  // word counter walks the line
  assign mem_adr_o = {base_q, cnt_q, {BYTE_OFFS_BITS{1'b0}}};

  assign fill.beat_ack  = mem_req_o & mem_ack_i & ~mem_err_i;
  assign fill.beat_word = mem_q_i;
  assign fill.beat_idx  = cnt_q;
  assign fill.err       = mem_req_o & mem_err_i;
  assign fill.line      = line_q;

  // single read ends after one beat
  assign last_beat = ~line_mode_q | (cnt_q == WORD_OFFS_BITS'(LINE_WORDS - 1));

  //////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      mem_req_o   <= 1'b0;
      fill.done   <= 1'b0;
      line_mode_q <= 1'b0;
      cnt_q       <= '0;
    end
    else
    begin
      // done one cycle after the last beat or the error
      fill.done <= fill.err | (fill.beat_ack & last_beat);

      if (!mem_req_o)
      begin
        if (fill.cmd == FILL_LINE)
        begin
          // bursts always start at word 0
          mem_req_o   <= 1'b1;
          line_mode_q <= 1'b1;
          cnt_q       <= '0;
        end
        else if (fill.cmd == FILL_WORD)
        begin
          mem_req_o   <= 1'b1;
          line_mode_q <= 1'b0;
          cnt_q       <= fill.adr[BYTE_OFFS_BITS +: WORD_OFFS_BITS];
        end
      end
      else if (fill.err || (fill.beat_ack && last_beat))
        mem_req_o <= 1'b0;
      else if (fill.beat_ack)
        cnt_q <= cnt_q + 1'b1;
    end

  // line base held for the whole transfer
  always_ff @(posedge clk_i)
    if (!mem_req_o && fill.cmd != FILL_NOP)
      base_q <= fill.adr[PLEN-1 -: BASE_BITS];

  // line buffer, slot picked by the word counter
  always_ff @(posedge clk_i)
    if (fill.beat_ack)
      line_q[cnt_q * XLEN +: XLEN] <= mem_q_i;

endmodule

// ==== source/icache_top.sv ====
/*
  two-way set-associative instruction cache
  controller, arrays and fill unit behind plain fetch and memory ports
*/

`timescale 1ns/100ps

module icache_top
  import icache_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // fetch stage
  input  logic                 req_i,
  input  logic [PLEN-1:0]      adr_i,
  input  logic                 cacheable_i,
  input  logic                 flush_i,
  input  logic                 invalidate_i,
  output logic                 stall_o,
  output logic [XLEN-1:0]      parcel_o,
  output logic                 parcel_valid_o,
  output logic                 parcel_error_o,
  output logic                 parcel_misaligned_o,

  // memory port
  output logic                 mem_req_o,
  output logic [PLEN-1:0]      mem_adr_o,
  input  logic                 mem_ack_i,
  input  logic [XLEN-1:0]      mem_q_i,
  input  logic                 mem_err_i
);

  logic                        hit;
  logic [XLEN-1:0]             hit_word;
  logic                        invalidate_all;

  // controller, fill unit and arrays share one fill bus
  icache_fill_if fill_bus ();

  icache_fsm fsm0 (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .adr_i               (adr_i),
    .cacheable_i         (cacheable_i),
    .flush_i             (flush_i),
    .invalidate_i        (invalidate_i),
    .stall_o             (stall_o),
    .parcel_o            (parcel_o),
    .parcel_valid_o      (parcel_valid_o),
    .parcel_error_o      (parcel_error_o),
    .parcel_misaligned_o (parcel_misaligned_o),
    .hit_i               (hit),
    .hit_word_i          (hit_word),
    .invalidate_all_o    (invalidate_all),
    .fill                (fill_bus.ctrl)
  );

  // lookup uses the live fetch address
  icache_memory mem0 (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .adr_i               (adr_i),
    .invalidate_all_i    (invalidate_all),
    .hit_o               (hit),
    .hit_word_o          (hit_word),
    .fill                (fill_bus.memory)
  );

  icache_fill fill0 (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .mem_req_o           (mem_req_o),
    .mem_adr_o           (mem_adr_o),
    .mem_ack_i           (mem_ack_i),
    .mem_q_i             (mem_q_i),
    .mem_err_i           (mem_err_i),
    .fill                (fill_bus.filler)
  );

endmodule

// ==== testbench/icache_tb.sv ====
/*
  testbench for the two-way instruction cache
  random fetches against a memory model with variable latency,
  checked with a last-filled-line reference model
*/

`timescale 1ns/100ps

module icache_tb
  import icache_pkg::*;
();

  localparam int CLK_PERIOD  = 10;
  localparam int SEED        = 29887;
  localparam int MEM_AW      = 8;
  localparam int MEM_WORDS   = 1 << MEM_AW;
  localparam int LINE_LSB    = BYTE_OFFS_BITS + WORD_OFFS_BITS;
  localparam int NUM_RANDOM  = 40;
  // random reads and the directed fetches
  localparam int NUM_FETCHES = NUM_RANDOM + 9;

  logic              clk_i;
  logic              rst_ni;
  logic              req_i;
  logic [PLEN-1:0]   adr_i;
  logic              cacheable_i;
  logic              flush_i;
  logic              invalidate_i;
  logic              stall_o;
  logic [XLEN-1:0]   parcel_o;
  logic              parcel_valid_o;
  logic              parcel_error_o;
  logic              parcel_misaligned_o;
  logic              mem_req_o;
  logic [PLEN-1:0]   mem_adr_o;
  logic              mem_ack_i;
  logic [XLEN-1:0]   mem_q_i;
  logic              mem_err_i;

  // memory model state
  logic [XLEN-1:0]   mem_words [MEM_WORDS];
  int                bus_reads = 0;
  logic [PLEN-1:0]   last_read_adr;
  logic              err_armed;
  logic [PLEN-1:0]   err_adr;

  // reference model of the last good line and its residency
  logic [PLEN-1:0]   last_line;
  bit                last_valid;

  // results of the last fetch
  logic [XLEN-1:0]   got_word;
  logic              got_valid;
  logic              got_error;
  logic              got_misaligned;
  logic              got_stall;
  int                got_cycles;
  bit                bus_seen;
  int                reads_before;

  int                errors = 0;
  int                tests_passed = 0;
  int                tests_failed = 0;

  icache_top dut0 (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .adr_i               (adr_i),
    .cacheable_i         (cacheable_i),
    .flush_i             (flush_i),
    .invalidate_i        (invalidate_i),
    .stall_o             (stall_o),
    .parcel_o            (parcel_o),
    .parcel_valid_o      (parcel_valid_o),
    .parcel_error_o      (parcel_error_o),
    .parcel_misaligned_o (parcel_misaligned_o),
    .mem_req_o           (mem_req_o),
    .mem_adr_o           (mem_adr_o),
    .mem_ack_i           (mem_ack_i),
    .mem_q_i             (mem_q_i),
    .mem_err_i           (mem_err_i)
  );

  initial
    clk_i = 1'b0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [MEM_AW-1:0] word_index(input logic [PLEN-1:0] adr);
    return adr[BYTE_OFFS_BITS +: MEM_AW];
  endfunction

  // aligned address inside the modelled memory
  function automatic logic [PLEN-1:0] random_adr();
    logic [PLEN-1:0] a;
    a = '0;
    a[BYTE_OFFS_BITS +: MEM_AW] = MEM_AW'($urandom % MEM_WORDS);
    return a;
  endfunction

  function automatic bit model_hit(input logic [PLEN-1:0] adr);
    return last_valid && ((adr >> LINE_LSB) == last_line);
  endfunction

  task automatic record_fill(input logic [PLEN-1:0] adr);
    last_line  = adr >> LINE_LSB;
    last_valid = 1'b1;
  endtask

  task automatic value_error(input string name, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
    errors++;
    $display("ERROR t=%0t %s expected 0x%08h actual 0x%08h", $time, name, expected, actual);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("t=%0t %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input int start_errors);
    if (errors == start_errors)
    begin
      tests_passed++;
      $display("test %-32s ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %-32s FAILED, %0d errors", name, errors - start_errors);
    end
  endtask

  // hold the request until a word, an error or a misaligned flag comes back
  task automatic fetch(input logic [PLEN-1:0] adr, input logic cacheable);
    bit done;
    done         = 1'b0;
    bus_seen     = 1'b0;
    got_cycles   = 0;
    reads_before = bus_reads;
    @(posedge clk_i);
    #1;
    req_i       = 1'b1;
    adr_i       = adr;
    cacheable_i = cacheable;
    while (!done)
    begin
      @(negedge clk_i);
      got_cycles++;
      if (mem_req_o)
        bus_seen = 1'b1;
      if (parcel_valid_o || parcel_error_o || parcel_misaligned_o)
      begin
        got_word       = parcel_o;
        got_valid      = parcel_valid_o;
        got_error      = parcel_error_o;
        got_misaligned = parcel_misaligned_o;
        got_stall      = stall_o;
        done           = 1'b1;
      end
    end
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    // rest of the burst
    while (mem_req_o)
    begin
      @(posedge clk_i);
      #1;
    end
    // bus stays watched through RECOVER0 and RECOVER1
    repeat (3)
    begin
      @(posedge clk_i);
      #1;
      if (mem_req_o)
        bus_seen = 1'b1;
    end
  endtask

  // one cycle pulse followed by a stall through INVALIDATE, RECOVER0 and RECOVER1
  task automatic invalidate_cache();
    int stall_cycles;
    stall_cycles = 0;
    @(posedge clk_i);
    #1;
    invalidate_i = 1'b1;
    @(posedge clk_i);
    #1;
    invalidate_i = 1'b0;
    repeat (5)
    begin
      @(negedge clk_i);
      if (stall_o)
        stall_cycles++;
    end
    if (stall_cycles != 3)
      note_failure($sformatf("invalidate stalled %0d cycles instead of 3", stall_cycles));
    last_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory model with 1 to 3 cycles per word
  //////////////////////////////////////////////////////////////////////

  initial
  begin : memory_model
    int remaining;
    bit busy;
    busy      = 1'b0;
    remaining = 0;
    forever
    begin
      @(posedge clk_i);
      #1;
      mem_ack_i = 1'b0;
      mem_err_i = 1'b0;
      if (mem_req_o !== 1'b1)
        busy = 1'b0;
      else
      begin
        // new word on the port
        if (!busy)
        begin
          busy      = 1'b1;
          remaining = $urandom % 3;
        end
        if (remaining > 0)
          remaining--;
        else
        begin
          busy = 1'b0;
          bus_reads++;
          last_read_adr = mem_adr_o;
          if (err_armed && mem_adr_o == err_adr)
          begin
            err_armed = 1'b0;
            mem_err_i = 1'b1;
          end
          else
          begin
            mem_ack_i = 1'b1;
            mem_q_i   = mem_words[word_index(mem_adr_o)];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  initial
  begin : main
    logic [PLEN-1:0] adr;
    logic [PLEN-1:0] adr2;
    logic [XLEN-1:0] old_word;
    logic [XLEN-1:0] exp_word;
    bit              expect_hit;
    int              start_errors;
    void'($urandom(SEED));
    rst_ni       = 1'b0;
    req_i        = 1'b0;
    adr_i        = '0;
    cacheable_i  = 1'b0;
    flush_i      = 1'b0;
    invalidate_i = 1'b0;
    mem_ack_i    = 1'b0;
    mem_q_i      = '0;
    mem_err_i    = 1'b0;
    err_armed    = 1'b0;
    err_adr      = '0;
    last_line    = '0;
    last_valid   = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++)
      mem_words[i] = $urandom;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // random cacheable reads
    start_errors = errors;
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      adr        = random_adr();
      expect_hit = model_hit(adr);
      exp_word   = mem_words[word_index(adr)];
      fetch(adr, 1'b1);
      if (got_valid !== 1'b1)
        value_error("parcel_valid_o", 1, got_valid);
      if (got_word !== exp_word)
        value_error("parcel_o", exp_word, got_word);
      if (expect_hit && bus_seen)
        value_error("mem_req_o", 0, 1);
      record_fill(adr);
    end
    finish_test("random cacheable reads", start_errors);

    // repeat hit keeps the old word after memory changed
    start_errors = errors;
    adr = random_adr();
    fetch(adr, 1'b1);
    record_fill(adr);
    adr2 = adr;
    adr2[BYTE_OFFS_BITS +: WORD_OFFS_BITS] = WORD_OFFS_BITS'($urandom);
    old_word = mem_words[word_index(adr2)];
    mem_words[word_index(adr2)] = ~old_word;
    fetch(adr2, 1'b1);
    if (got_valid !== 1'b1)
      value_error("parcel_valid_o", 1, got_valid);
    if (got_word !== old_word)
      value_error("parcel_o", old_word, got_word);
    if (bus_seen)
      value_error("mem_req_o", 0, 1);
    if (got_stall !== 1'b0)
      value_error("stall_o", 0, got_stall);
    if (got_cycles != 1)
      note_failure($sformatf("hit answered after %0d cycles, not in the first", got_cycles));
    finish_test("repeat fetch from filled line", start_errors);

    // noncacheable single read without a fill
    start_errors = errors;
    invalidate_cache();
    adr      = random_adr();
    exp_word = mem_words[word_index(adr)];
    fetch(adr, 1'b0);
    if (got_valid !== 1'b1)
      value_error("parcel_valid_o", 1, got_valid);
    if (got_word !== exp_word)
      value_error("parcel_o", exp_word, got_word);
    if (bus_reads - reads_before != 1)
      note_failure($sformatf("noncacheable fetch made %0d memory reads, not one",
                             bus_reads - reads_before));
    if (last_read_adr !== adr)
      value_error("mem_adr_o", adr, last_read_adr);
    fetch(adr, 1'b1);
    if (!bus_seen)
      note_failure("line was resident after a noncacheable fetch");
    if (got_word !== exp_word)
      value_error("parcel_o", exp_word, got_word);
    record_fill(adr);
    finish_test("noncacheable fetch", start_errors);

    // invalidate drops the resident line
    start_errors = errors;
    adr = random_adr();
    fetch(adr, 1'b1);
    record_fill(adr);
    mem_words[word_index(adr)] = ~mem_words[word_index(adr)];
    exp_word = mem_words[word_index(adr)];
    invalidate_cache();
    fetch(adr, 1'b1);
    if (!bus_seen)
      note_failure("fetch after invalidate did not request the bus");
    if (got_word !== exp_word)
      value_error("parcel_o", exp_word, got_word);
    record_fill(adr);
    finish_test("invalidate", start_errors);

    // error on the first beat of a line leaves nothing written
    start_errors = errors;
    invalidate_cache();
    adr     = random_adr();
    err_adr = adr;
    err_adr[LINE_LSB-1:0] = '0;
    err_armed = 1'b1;
    fetch(adr, 1'b1);
    if (got_error !== 1'b1)
      value_error("parcel_error_o", 1, got_error);
    if (got_valid !== 1'b0)
      value_error("parcel_valid_o", 0, got_valid);
    exp_word = mem_words[word_index(adr)];
    fetch(adr, 1'b1);
    if (!bus_seen)
      note_failure("failed line was treated as resident");
    if (got_word !== exp_word)
      value_error("parcel_o", exp_word, got_word);
    record_fill(adr);
    finish_test("bus error", start_errors);

    // misaligned fetch
    start_errors = errors;
    adr = random_adr() | PLEN'(1 + $urandom % 3);
    fetch(adr, 1'b1);
    if (got_misaligned !== 1'b1)
      value_error("parcel_misaligned_o", 1, got_misaligned);
    if (got_valid !== 1'b0)
      value_error("parcel_valid_o", 0, got_valid);
    if (bus_seen || bus_reads != reads_before)
      note_failure("misaligned fetch caused memory traffic");
    finish_test("misaligned fetch", start_errors);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // stops a hung run
  initial
  begin : watchdog
    ctrl_state_t state_now;
    repeat (NUM_FETCHES * 40) @(posedge clk_i);
    state_now = dut0.fsm0.state;
    $display("timeout after %0d cycles, the tests did not finish, controller in %s",
             NUM_FETCHES * 40, state_now.name());
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== sources.f ====
common/icache_pkg.sv
common/icache_fill_if.sv
icache/icache_fsm.sv
icache/icache_memory.sv
icache/icache_fill.sv
source/icache_top.sv
testbench/icache_tb.sv
